/* verilog/soc_bus_pkg.sv */
package soc_bus_pkg;

	// --------------------
	// Wishbone widths
	// --------------------
	localparam int WB_ADR_WIDTH = 32;
	localparam int WB_DATA_WIDTH = 32;
	// One select line per byte lane
	localparam int WB_SEL_WIDTH = WB_DATA_WIDTH / 8;

	// CSR address splits into bank and register
	localparam int CSR_BANK_WIDTH = 4;
	localparam int CSR_REG_WIDTH = 10;
	localparam int CSR_ADR_WIDTH = CSR_BANK_WIDTH + CSR_REG_WIDTH;

	typedef logic [WB_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [WB_DATA_WIDTH-1:0] wb_data_t;
	typedef logic [WB_SEL_WIDTH-1:0] wb_sel_t;

	// Master to slave
	typedef struct packed {
		wb_adr_t adr;
		wb_data_t dat;
		wb_sel_t sel;
		logic we;
		logic cyc;
		logic stb;
	} wb_req_t;

	// Slave to master
	typedef struct packed {
		wb_data_t dat;
		logic ack;
	} wb_rsp_t;

	typedef logic [CSR_ADR_WIDTH-1:0] csr_adr_t;
	typedef logic [CSR_BANK_WIDTH-1:0] csr_bank_t;
	typedef logic [CSR_REG_WIDTH-1:0] csr_reg_t;

	// Bridge to CSR slaves, no handshake
	typedef struct packed {
		csr_adr_t adr;
		logic we;
		wb_data_t dat;
	} csr_req_t;

endpackage

/* verilog/soc_map_pkg.sv */
package soc_map_pkg;

	// --------------------
	// Address map
	// --------------------
	// Top 3 address bits pick the region
	localparam int REGION_LSB = 29;
	localparam soc_bus_pkg::wb_adr_t BRAM_BASE = 32'h2000_0000;
	localparam soc_bus_pkg::wb_adr_t CSR_BASE = 32'h8000_0000;

	typedef enum logic [2:0] {
		REGION_NONE = 3'b000,
		REGION_BRAM = BRAM_BASE[31:REGION_LSB],
		REGION_CSR = CSR_BASE[31:REGION_LSB]
	} region_e;

	// Read back from every unpopulated region
	localparam soc_bus_pkg::wb_data_t STUB_WORD = 32'habadface;

	// --------------------
	// CSR banks
	// --------------------
	localparam soc_bus_pkg::csr_bank_t SYSCTL_BANK = 4'd1;

	// System controller registers, word index within the bank
	typedef enum logic [9:0] {
		REG_GPIO_IN = 10'd0,
		REG_GPIO_OUT = 10'd1,
		REG_IRQ_EN = 10'd2,
		REG_IRQ_PENDING = 10'd3,
		REG_SYSTEM_ID = 10'd4,
		REG_HARD_RESET = 10'd5
	} sysctl_reg_e;

	// Wishbone to CSR bridge sequence
	typedef enum logic [1:0] {
		CSR_IDLE,
		CSR_ISSUE,
		CSR_CAPTURE,
		CSR_ACK
	} csr_state_e;

endpackage

/* verilog/reset_gen.sv */
`timescale 1ns/1ns

module reset_gen #(
	parameter int DEBOUNCE_CYCLES = 16
) (
	input logic sys_clk,
	input logic rst_n_i,
	input logic hard_reset_req_i,
	output logic core_rst_n_o
);

	localparam int CNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);

	logic rst_meta;
	logic rst_sync;
	logic [CNT_WIDTH-1:0] cnt_q;

	// --------------------
	// Synchronizer
	// --------------------
	// Asserts at once, releases two edges later
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rst_meta <= 1'b0;
			rst_sync <= 1'b0;
		end else begin
			rst_meta <= 1'b1;
			rst_sync <= rst_meta;
		end
	end

	// --------------------
	// Debounce stretcher
	// --------------------
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cnt_q <= CNT_WIDTH'(DEBOUNCE_CYCLES);
			core_rst_n_o <= 1'b0;
		end else begin
			// Pin still low or software hard reset reloads
			if (!rst_sync || hard_reset_req_i) begin
				cnt_q <= CNT_WIDTH'(DEBOUNCE_CYCLES);
			end else if (cnt_q != '0) begin
				cnt_q <= cnt_q - 1'b1;
			end
			// Released only once the count has run out
			core_rst_n_o <= (cnt_q == '0);
		end
	end

endmodule

/* verilog/wb_decoder.sv */
`timescale 1ns/1ns

module wb_decoder (
	input logic sys_clk,
	input logic rst_n_i,
	input soc_bus_pkg::wb_req_t m_req_i,
	output soc_bus_pkg::wb_rsp_t m_rsp_o,
	output soc_bus_pkg::wb_req_t bram_req_o,
	input soc_bus_pkg::wb_rsp_t bram_rsp_i,
	output soc_bus_pkg::wb_req_t csr_req_o,
	input soc_bus_pkg::wb_rsp_t csr_rsp_i
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	region_e region;
	logic stub_hit;
	logic stub_ack_q;

	// --------------------
	// Region decode
	// --------------------
	always_comb begin
		case (m_req_i.adr[WB_ADR_WIDTH-1:REGION_LSB])
			REGION_BRAM: region = REGION_BRAM;
			REGION_CSR: region = REGION_CSR;
			// Flash, FML, USB, Ethernet holes and the rest
			default: region = REGION_NONE;
		endcase
	end

	// Whole request fans out, only stb is steered
	always_comb begin
		bram_req_o = m_req_i;
		bram_req_o.stb = m_req_i.stb && (region == REGION_BRAM);
		csr_req_o = m_req_i;
		csr_req_o.stb = m_req_i.stb && (region == REGION_CSR);
	end

	// --------------------
	// Stub responder
	// --------------------
	assign stub_hit = m_req_i.cyc && m_req_i.stb && (region == REGION_NONE);

	// Single cycle ack, dropped again while the master still holds stb
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			stub_ack_q <= 1'b0;
		end else begin
			stub_ack_q <= stub_hit && !stub_ack_q;
		end
	end

	// Response mux follows the address held by the master
	always_comb begin
		case (region)
			REGION_BRAM: m_rsp_o = bram_rsp_i;
			REGION_CSR: m_rsp_o = csr_rsp_i;
			default: begin
				m_rsp_o.dat = STUB_WORD;
				// No ack left over for an abandoned cycle
				m_rsp_o.ack = stub_ack_q && stub_hit;
			end
		endcase
	end

endmodule

/* verilog/bram_slave.sv */
`timescale 1ns/1ns

module bram_slave #(
	parameter int BRAM_ADR_WIDTH = 10
) (
	input logic sys_clk,
	input logic rst_n_i,
	input soc_bus_pkg::wb_req_t req_i,
	output soc_bus_pkg::wb_rsp_t rsp_o
);

	import soc_bus_pkg::*;

	localparam int DEPTH = 2 ** BRAM_ADR_WIDTH;

	wb_data_t mem [DEPTH];
	wb_data_t rdata_q;
	logic [BRAM_ADR_WIDTH-1:0] word_adr;
	logic access;
	logic ack_q;

	// Word index, byte offset dropped
	assign word_adr = req_i.adr[BRAM_ADR_WIDTH+1:2];
	// First cycle of a transfer only
	assign access = req_i.cyc && req_i.stb && !ack_q;

	// --------------------
	// Memory array
	// --------------------
	always_ff @(posedge sys_clk) begin
		if (access) begin
			if (req_i.we) begin
				// Merge selected byte lanes only
				for (int i = 0; i < WB_SEL_WIDTH; i++) begin
					if (req_i.sel[i]) begin
						mem[word_adr][8*i +: 8] <= req_i.dat[8*i +: 8];
					end
				end
			end
			rdata_q <= mem[word_adr];
		end
	end

	// Ack one edge after stb is seen
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign rsp_o.dat = rdata_q;
	assign rsp_o.ack = ack_q && req_i.cyc && req_i.stb;

endmodule

/* verilog/csr_bridge.sv */
`timescale 1ns/1ns

module csr_bridge (
	input logic sys_clk,
	input logic rst_n_i,
	input soc_bus_pkg::wb_req_t wb_req_i,
	output soc_bus_pkg::wb_rsp_t wb_rsp_o,
	output soc_bus_pkg::csr_req_t csr_o,
	input soc_bus_pkg::wb_data_t csr_rdata_i
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	csr_state_e state_q;
	csr_state_e state_d;
	logic req_valid;
	logic csr_we_q;
	csr_adr_t csr_adr_q;
	wb_data_t csr_dat_q;
	wb_data_t rdata_q;

	assign req_valid = wb_req_i.cyc && wb_req_i.stb;

	// --------------------
	// Sequencer
	// --------------------
	// Write: issue, ack
	// Read: issue, capture, ack
	always_comb begin
		state_d = state_q;
		case (state_q)
			CSR_IDLE: if (req_valid) state_d = CSR_ISSUE;
			CSR_ISSUE: begin
				if (!req_valid) state_d = CSR_IDLE;
				else if (wb_req_i.we) state_d = CSR_ACK;
				else state_d = CSR_CAPTURE;
			end
			CSR_CAPTURE: state_d = req_valid ? CSR_ACK : CSR_IDLE;
			default: state_d = CSR_IDLE;
		endcase
	end

	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= CSR_IDLE;
			csr_we_q <= 1'b0;
		end else begin
			state_q <= state_d;
			// Write strobe lives only in the issue cycle
			csr_we_q <= (state_q == CSR_IDLE) && req_valid && wb_req_i.we;
		end
	end

	// Address and write word latched as the access starts
	always_ff @(posedge sys_clk) begin
		if (state_q == CSR_IDLE && req_valid) begin
			csr_adr_q <= wb_req_i.adr[CSR_ADR_WIDTH+1:2];
			csr_dat_q <= wb_req_i.dat;
		end
		// Slaves register their read word one cycle after issue
		if (state_q == CSR_CAPTURE) begin
			rdata_q <= csr_rdata_i;
		end
	end

	assign csr_o.adr = csr_adr_q;
	assign csr_o.we = csr_we_q;
	assign csr_o.dat = csr_dat_q;

	assign wb_rsp_o.dat = rdata_q;
	assign wb_rsp_o.ack = (state_q == CSR_ACK) && req_valid;

endmodule

/* verilog/sysctl.sv */
`timescale 1ns/1ns

module sysctl #(
	parameter soc_bus_pkg::csr_bank_t CSR_BANK = soc_map_pkg::SYSCTL_BANK,
	parameter int NINPUTS = 13,
	parameter int NOUTPUTS = 14,
	parameter soc_bus_pkg::wb_data_t SYSTEM_ID = 32'h58343031
) (
	input logic sys_clk,
	input logic rst_n_i,
	input soc_bus_pkg::csr_req_t csr_i,
	output soc_bus_pkg::wb_data_t csr_rdata_o,
	input logic [NINPUTS-1:0] gpio_i,
	output logic [NOUTPUTS-1:0] gpio_o,
	output logic gpio_irq_o,
	output logic hard_reset_req_o
);

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	logic [NINPUTS-1:0] gpio_meta;
	logic [NINPUTS-1:0] gpio_sync;
	logic [NINPUTS-1:0] gpio_prev;
	logic [NINPUTS-1:0] irq_en_q;
	logic [NINPUTS-1:0] irq_pending_q;
	logic [NINPUTS-1:0] pending_set;
	logic [NINPUTS-1:0] pending_clr;
	logic bank_hit;
	logic wr_hit;
	sysctl_reg_e reg_sel;
	wb_data_t rd_word;

	// --------------------
	// Address decode
	// --------------------
	assign bank_hit = (csr_i.adr[CSR_REG_WIDTH +: CSR_BANK_WIDTH] == CSR_BANK);
	assign reg_sel = sysctl_reg_e'(csr_i.adr[CSR_REG_WIDTH-1:0]);
	assign wr_hit = csr_i.we && bank_hit;

	// --------------------
	// GPIO inputs
	// --------------------
	// Two flop sync, third flop for change detect
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gpio_meta <= '0;
			gpio_sync <= '0;
			gpio_prev <= '0;
		end else begin
			gpio_meta <= gpio_i;
			gpio_sync <= gpio_meta;
			gpio_prev <= gpio_sync;
		end
	end

	// Any edge on an enabled bit, set beats clear
	assign pending_set = irq_en_q & (gpio_sync ^ gpio_prev);
	assign pending_clr = (wr_hit && reg_sel == REG_IRQ_PENDING) ? csr_i.dat[NINPUTS-1:0] : '0;
	assign gpio_irq_o = |irq_pending_q;

	// --------------------
	// Register writes
	// --------------------
	always_ff @(posedge sys_clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gpio_o <= '0;
			irq_en_q <= '0;
			irq_pending_q <= '0;
			hard_reset_req_o <= 1'b0;
		end else begin
			irq_pending_q <= (irq_pending_q & ~pending_clr) | pending_set;
			// One cycle request, data word ignored
			hard_reset_req_o <= wr_hit && (reg_sel == REG_HARD_RESET);
			if (wr_hit) begin
				case (reg_sel)
					REG_GPIO_OUT: gpio_o <= csr_i.dat[NOUTPUTS-1:0];
					REG_IRQ_EN: irq_en_q <= csr_i.dat[NINPUTS-1:0];
					default: ;
				endcase
			end
		end
	end

	// --------------------
	// Read mux
	// --------------------
	always_comb begin
		rd_word = '0;
		// Other banks and unlisted registers read zero
		if (bank_hit) begin
			case (reg_sel)
				REG_GPIO_IN: rd_word[NINPUTS-1:0] = gpio_sync;
				REG_GPIO_OUT: rd_word[NOUTPUTS-1:0] = gpio_o;
				REG_IRQ_EN: rd_word[NINPUTS-1:0] = irq_en_q;
				REG_IRQ_PENDING: rd_word[NINPUTS-1:0] = irq_pending_q;
				REG_SYSTEM_ID: rd_word = SYSTEM_ID;
				default: rd_word = '0;
			endcase
		end
	end

	// Registered, bridge samples it one cycle after issue
	always_ff @(posedge sys_clk) begin
		csr_rdata_o <= rd_word;
	end

endmodule

/* verilog/soc_top.sv */
`timescale 1ns/1ns

module soc_top #(
	parameter int BRAM_ADR_WIDTH = 10,
	parameter int DEBOUNCE_CYCLES = 16,
	parameter soc_bus_pkg::csr_bank_t CSR_BANK = soc_map_pkg::SYSCTL_BANK,
	parameter int NINPUTS = 13,
	parameter int NOUTPUTS = 14,
	// X401
	parameter soc_bus_pkg::wb_data_t SYSTEM_ID = 32'h58343031
) (
	input logic sys_clk,
	input logic rst_n_i,
	input soc_bus_pkg::wb_req_t wb_req_i,
	output soc_bus_pkg::wb_rsp_t wb_rsp_o,
	input logic [NINPUTS-1:0] gpio_i,
	output logic [NOUTPUTS-1:0] gpio_o,
	output logic gpio_irq_o
);

	import soc_bus_pkg::*;

	logic core_rst_n;
	logic hard_reset_req;
	wb_req_t bram_req;
	wb_rsp_t bram_rsp;
	wb_req_t csr_wb_req;
	wb_rsp_t csr_wb_rsp;
	csr_req_t csr_req;
	wb_data_t csr_rdata;

	// --------------------
	// Reset
	// --------------------
	reset_gen #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_reset_gen (
		.sys_clk(sys_clk),
		.rst_n_i(rst_n_i),
		.hard_reset_req_i(hard_reset_req),
		.core_rst_n_o(core_rst_n)
	);

	// --------------------
	// Wishbone side
	// --------------------
	wb_decoder u_wb_decoder (
		.sys_clk(sys_clk),
		.rst_n_i(core_rst_n),
		.m_req_i(wb_req_i),
		.m_rsp_o(wb_rsp_o),
		.bram_req_o(bram_req),
		.bram_rsp_i(bram_rsp),
		.csr_req_o(csr_wb_req),
		.csr_rsp_i(csr_wb_rsp)
	);

	bram_slave #(
		.BRAM_ADR_WIDTH(BRAM_ADR_WIDTH)
	) u_bram_slave (
		.sys_clk(sys_clk),
		.rst_n_i(core_rst_n),
		.req_i(bram_req),
		.rsp_o(bram_rsp)
	);

	csr_bridge u_csr_bridge (
		.sys_clk(sys_clk),
		.rst_n_i(core_rst_n),
		.wb_req_i(csr_wb_req),
		.wb_rsp_o(csr_wb_rsp),
		.csr_o(csr_req),
		.csr_rdata_i(csr_rdata)
	);

	// --------------------
	// CSR side
	// --------------------
	// Only slave on the bus, so its word is the whole read bus
	sysctl #(
		.CSR_BANK(CSR_BANK),
		.NINPUTS(NINPUTS),
		.NOUTPUTS(NOUTPUTS),
		.SYSTEM_ID(SYSTEM_ID)
	) u_sysctl (
		.sys_clk(sys_clk),
		.rst_n_i(core_rst_n),
		.csr_i(csr_req),
		.csr_rdata_o(csr_rdata),
		.gpio_i(gpio_i),
		.gpio_o(gpio_o),
		.gpio_irq_o(gpio_irq_o),
		.hard_reset_req_o(hard_reset_req)
	);

endmodule

/* tb/soc_assertions.sv */
`timescale 1ns/1ns

module soc_assertions #(
	parameter int NOUTPUTS = 14
) (
	input logic sys_clk,
	input logic core_rst_n_i,
	input soc_bus_pkg::wb_req_t wb_req_i,
	input soc_bus_pkg::wb_rsp_t wb_rsp_i,
	input logic [NOUTPUTS-1:0] gpio_i
);

	// Failed assertions so far, watched by the testbench
	int error_count = 0;

	// --------------------
	// Wishbone handshake
	// --------------------
	// One ack per transfer, never two in a row
	ack_single: assert property (@(posedge sys_clk) disable iff (!core_rst_n_i)
		wb_rsp_i.ack |=> !wb_rsp_i.ack)
	else begin
		error_count++;
		$error("ack high in two consecutive cycles");
	end

	// Ack only inside an active cycle
	ack_in_cycle: assert property (@(posedge sys_clk) disable iff (!core_rst_n_i)
		wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
	else begin
		error_count++;
		$error("ack without cyc and stb");
	end

	// --------------------
	// Reset behavior
	// --------------------
	gpio_reset: assert property (@(posedge sys_clk)
		!core_rst_n_i |-> (gpio_i == '0))
	else begin
		error_count++;
		$error("gpio_o not cleared during core reset");
	end

endmodule

// Core reset and bus taken from inside the top level
bind soc_top soc_assertions #(
	.NOUTPUTS(NOUTPUTS)
) u_soc_assertions (
	.sys_clk(sys_clk),
	.core_rst_n_i(core_rst_n),
	.wb_req_i(wb_req_i),
	.wb_rsp_i(wb_rsp_o),
	.gpio_i(gpio_o)
);

/* tb/tb_soc.sv */
`timescale 1ns/1ns

module tb_soc;

	import soc_bus_pkg::*;
	import soc_map_pkg::*;

	localparam int BRAM_ADR_WIDTH = 10;
	localparam int DEBOUNCE_CYCLES = 16;
	localparam csr_bank_t CSR_BANK = SYSCTL_BANK;
	localparam int NINPUTS = 13;
	localparam int NOUTPUTS = 14;
	localparam wb_data_t SYSTEM_ID = 32'h58343031;
	// Wait limits, in cycles or reads
	localparam int ACK_TIMEOUT = 16;
	localparam int RESET_TIMEOUT = 4 * (DEBOUNCE_CYCLES + 4);
	localparam int IRQ_TIMEOUT = 16;
	localparam int POLL_LIMIT = 8;
	localparam int RAM_WORDS = 32;

	logic sys_clk;
	logic rst_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	logic [NINPUTS-1:0] gpio_in;
	logic [NOUTPUTS-1:0] gpio_out;
	logic gpio_irq;
	int seed;

	// Shadow model of RAM and sysctl registers
	wb_data_t ram_model [int];
	logic [NOUTPUTS-1:0] gpio_out_model;
	logic [NINPUTS-1:0] irq_en_model;
	logic [NINPUTS-1:0] irq_pending_model;

	soc_top #(
		.BRAM_ADR_WIDTH(BRAM_ADR_WIDTH),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.CSR_BANK(CSR_BANK),
		.NINPUTS(NINPUTS),
		.NOUTPUTS(NOUTPUTS),
		.SYSTEM_ID(SYSTEM_ID)
	) uut (
		.sys_clk(sys_clk),
		.rst_n_i(rst_n),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp),
		.gpio_i(gpio_in),
		.gpio_o(gpio_out),
		.gpio_irq_o(gpio_irq)
	);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// --------------------
	// Reference model
	// --------------------
	function automatic wb_adr_t csr_addr(input csr_bank_t bank, input csr_reg_t index);
		return CSR_BASE + bank * 32'h1000 + index * 4;
	endfunction

	// Expected read word from the address map and the shadow state
	function automatic wb_data_t expected_read(input wb_adr_t adr);
		wb_data_t word;
		word = '0;
		case (adr[31:29])
			3'b001: word = ram_model[int'(adr[BRAM_ADR_WIDTH+1:2])];
			3'b100: begin
				// Foreign banks stay zero
				if (adr[15:12] == CSR_BANK) begin
					case (adr[11:2])
						REG_GPIO_IN: word[NINPUTS-1:0] = gpio_in;
						REG_GPIO_OUT: word[NOUTPUTS-1:0] = gpio_out_model;
						REG_IRQ_EN: word[NINPUTS-1:0] = irq_en_model;
						REG_IRQ_PENDING: word[NINPUTS-1:0] = irq_pending_model;
						REG_SYSTEM_ID: word = SYSTEM_ID;
						default: word = '0;
					endcase
				end
			end
			default: word = STUB_WORD;
		endcase
		return word;
	endfunction

	// Write side effects on the shadow state
	function automatic void track_write(input wb_adr_t adr, input wb_data_t dat,
			input wb_sel_t sel);
		int idx;
		idx = int'(adr[BRAM_ADR_WIDTH+1:2]);
		if (adr[31:29] == 3'b001) begin
			for (int i = 0; i < 4; i++) begin
				if (sel[i]) ram_model[idx][8*i +: 8] = dat[8*i +: 8];
			end
		end else if (adr[31:29] == 3'b100 && adr[15:12] == CSR_BANK) begin
			case (adr[11:2])
				REG_GPIO_OUT: gpio_out_model = dat[NOUTPUTS-1:0];
				REG_IRQ_EN: irq_en_model = dat[NINPUTS-1:0];
				// Write one to clear
				REG_IRQ_PENDING: irq_pending_model = irq_pending_model & ~dat[NINPUTS-1:0];
				default: ;
			endcase
		end
	endfunction

	// --------------------
	// Checks
	// --------------------
	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input wb_data_t exp, input wb_data_t got);
		if (got !== exp) begin
			abort_run($sformatf("mismatch %s exp 0x%08h got 0x%08h", name, exp, got));
		end
	endtask

	task automatic check_gpio(input logic [NOUTPUTS-1:0] exp, input logic [NOUTPUTS-1:0] got);
		if (got !== exp) begin
			abort_run($sformatf("mismatch gpio_o exp 0x%04h got 0x%04h", exp, got));
		end
	endtask

	task automatic check_irq(input logic exp, input logic got);
		if (got !== exp) begin
			abort_run($sformatf("mismatch gpio_irq_o exp 0x%01h got 0x%01h", exp, got));
		end
	endtask

	// Bound checks count their own failures
	always @(negedge sys_clk) begin
		if (uut.u_soc_assertions.error_count != 0) abort_run("bound assertion failed");
	end

	// --------------------
	// Bus master
	// --------------------
	task automatic wb_cycle(input logic we, input wb_adr_t adr, input wb_data_t dat,
			input wb_sel_t sel, output wb_data_t rdata);
		int waited;
		@(posedge sys_clk);
		#2;
		wb_req.adr = adr;
		wb_req.dat = dat;
		wb_req.sel = sel;
		wb_req.we = we;
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		waited = 0;
		// Ack seen mid cycle is taken at the next edge
		@(negedge sys_clk);
		while (wb_rsp.ack !== 1'b1) begin
			if (waited == ACK_TIMEOUT) abort_run($sformatf("no ack for access at 0x%08h", adr));
			waited++;
			@(negedge sys_clk);
		end
		rdata = wb_rsp.dat;
		@(posedge sys_clk);
		#2;
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we = 1'b0;
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_data_t dat, input wb_sel_t sel);
		wb_data_t unused;
		wb_cycle(1'b1, adr, dat, sel, unused);
		track_write(adr, dat, sel);
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_data_t rdata);
		wb_cycle(1'b0, adr, '0, 4'hf, rdata);
	endtask

	task automatic read_and_check(input wb_adr_t adr);
		wb_data_t data;
		wb_read(adr, data);
		check_word($sformatf("wb_rsp_o.dat[0x%08h]", adr), expected_read(adr), data);
	endtask

	// Repeated reads while synchronizers settle
	task automatic poll_read(input wb_adr_t adr);
		wb_data_t data;
		int tries;
		tries = 0;
		wb_read(adr, data);
		while (data !== expected_read(adr) && tries < POLL_LIMIT) begin
			tries++;
			wb_read(adr, data);
		end
		check_word($sformatf("wb_rsp_o.dat[0x%08h]", adr), expected_read(adr), data);
	endtask

	task automatic wait_core_reset(input logic level);
		int waited;
		waited = 0;
		@(negedge sys_clk);
		while (uut.core_rst_n !== level) begin
			if (waited == RESET_TIMEOUT) abort_run("core reset did not change level in time");
			waited++;
			@(negedge sys_clk);
		end
	endtask

	task automatic wait_irq(input logic level);
		int waited;
		waited = 0;
		@(negedge sys_clk);
		while (gpio_irq !== level) begin
			if (waited == IRQ_TIMEOUT) abort_run("gpio interrupt did not change level in time");
			waited++;
			@(negedge sys_clk);
		end
	endtask

	// --------------------
	// Stimulus
	// --------------------
	initial begin
		wb_data_t data;
		wb_sel_t sel;
		int idx;
		logic [NINPUTS-1:0] gpio_prev;
		seed = 32'h40f4;
		rst_n = 1'b0;
		wb_req = '0;
		gpio_in = '0;
		gpio_out_model = '0;
		irq_en_model = '0;
		irq_pending_model = '0;
		repeat (10) @(posedge sys_clk);
		#2;
		rst_n = 1'b1;
		wait_core_reset(1'b1);

		// RAM fill, then byte lane merges
		for (idx = 0; idx < RAM_WORDS; idx++) wb_write(BRAM_BASE + idx * 4, $random(seed), 4'hf);
		for (int n = 0; n < 64; n++) begin
			idx = $unsigned($random(seed)) % RAM_WORDS;
			data = $random(seed);
			sel = wb_sel_t'($random(seed));
			wb_write(BRAM_BASE + idx * 4, data, sel);
		end
		for (idx = 0; idx < RAM_WORDS; idx++) read_and_check(BRAM_BASE + idx * 4);

		// Unpopulated regions, offsets alias RAM words
		for (int code = 0; code < 8; code++) begin
			if (code != REGION_BRAM && code != REGION_CSR) begin
				idx = $unsigned($random(seed)) % RAM_WORDS;
				wb_write({code[2:0], 29'(idx * 4)}, $random(seed), 4'hf);
				read_and_check({code[2:0], 29'(idx * 4)});
			end
		end
		for (idx = 0; idx < RAM_WORDS; idx++) read_and_check(BRAM_BASE + idx * 4);

		// System ID, GPIO out, empty registers
		read_and_check(csr_addr(CSR_BANK, REG_SYSTEM_ID));
		wb_write(csr_addr(CSR_BANK, REG_GPIO_OUT), $random(seed), 4'hf);
		check_gpio(gpio_out_model, gpio_out);
		read_and_check(csr_addr(CSR_BANK, REG_GPIO_OUT));
		read_and_check(csr_addr(CSR_BANK + 4'd1, REG_SYSTEM_ID));
		read_and_check(csr_addr(4'd0, REG_GPIO_OUT));
		read_and_check(csr_addr(CSR_BANK, 10'd9));

		// GPIO input and change interrupt
		@(posedge sys_clk);
		#2;
		gpio_in = NINPUTS'($random(seed));
		poll_read(csr_addr(CSR_BANK, REG_GPIO_IN));
		wb_write(csr_addr(CSR_BANK, REG_IRQ_EN), 32'h0000_00ff, 4'hf);
		check_irq(1'b0, gpio_irq);
		gpio_prev = gpio_in;
		@(posedge sys_clk);
		#2;
		// Bits 0 to 2 enabled, bit 10 masked
		gpio_in = gpio_in ^ 13'h0407;
		irq_pending_model = irq_pending_model | (irq_en_model & (gpio_prev ^ gpio_in));
		wait_irq(1'b1);
		read_and_check(csr_addr(CSR_BANK, REG_IRQ_PENDING));
		wb_write(csr_addr(CSR_BANK, REG_IRQ_PENDING), 32'h0000_0001, 4'hf);
		check_irq(1'b1, gpio_irq);
		read_and_check(csr_addr(CSR_BANK, REG_IRQ_PENDING));
		wb_write(csr_addr(CSR_BANK, REG_IRQ_PENDING), 32'h0000_0006, 4'hf);
		check_irq(1'b0, gpio_irq);
		read_and_check(csr_addr(CSR_BANK, REG_IRQ_PENDING));

		// One bit left pending into the hard reset
		gpio_prev = gpio_in;
		@(posedge sys_clk);
		#2;
		gpio_in = gpio_in ^ 13'h0001;
		irq_pending_model = irq_pending_model | (irq_en_model & (gpio_prev ^ gpio_in));
		wait_irq(1'b1);

		// Software hard reset
		wb_write(csr_addr(CSR_BANK, REG_HARD_RESET), $random(seed), 4'hf);
		wait_core_reset(1'b0);
		check_gpio('0, gpio_out);
		gpio_out_model = '0;
		irq_en_model = '0;
		irq_pending_model = '0;
		wait_core_reset(1'b1);
		read_and_check(csr_addr(CSR_BANK, REG_GPIO_OUT));
		read_and_check(csr_addr(CSR_BANK, REG_IRQ_EN));
		read_and_check(csr_addr(CSR_BANK, REG_IRQ_PENDING));
		read_and_check(csr_addr(CSR_BANK, REG_SYSTEM_ID));
		poll_read(csr_addr(CSR_BANK, REG_GPIO_IN));
		check_irq(1'b0, gpio_irq);
		// RAM keeps its contents
		for (idx = 0; idx < RAM_WORDS; idx++) read_and_check(BRAM_BASE + idx * 4);

		if (uut.u_soc_assertions.error_count != 0) begin
			abort_run("bound assertion failed");
		end else begin
			$display("Simulation passed");
			$finish;
		end
	end

endmodule

/* tb.f */
verilog/soc_bus_pkg.sv
verilog/soc_map_pkg.sv
verilog/reset_gen.sv
verilog/wb_decoder.sv
verilog/bram_slave.sv
verilog/csr_bridge.sv
verilog/sysctl.sv
verilog/soc_top.sv
tb/soc_assertions.sv
tb/tb_soc.sv

/* Bender.yml */
package:
  name: soc_backbone

sources:
  - files:
      - verilog/soc_bus_pkg.sv
      - verilog/soc_map_pkg.sv
      - verilog/reset_gen.sv
      - verilog/wb_decoder.sv
      - verilog/bram_slave.sv
      - verilog/csr_bridge.sv
      - verilog/sysctl.sv
      - verilog/soc_top.sv
  - target: simulation
    files:
      - tb/soc_assertions.sv
      - tb/tb_soc.sv
